/* rtl/aesPkg.sv */
// shared types, constants and field helpers of the AES-128 engine, referenced by scoped name
package aesPkg;

	// data widths
	typedef logic [127:0] aesBlockT;
	typedef logic [31:0] aesWordT;
	typedef logic [7:0] aesByteT;

	// round number, 0 to 10
	typedef logic [3:0] roundIndexT;

	// core control states
	typedef enum logic [1:0] {CORE_IDLE, CORE_ROUND, CORE_HOLD} coreStateT;

	// AES-128 runs ten rounds after the initial key addition
	localparam roundIndexT NUM_ROUNDS = 4'd10;

	// round constant of the first expansion step
	localparam aesByteT RCON_INIT = 8'h01;

	// x^8 = x^4 + x^3 + x + 1 folded back into the low byte
	localparam aesByteT GF_POLY = 8'h1b;

	// constant of the S-box affine map
	localparam aesByteT SBOX_AFFINE_CONST = 8'h63;

	// output credit counter saturates here
	localparam int OUT_CREDIT_MAX = 4;
	localparam int OUT_CREDIT_W = $clog2(OUT_CREDIT_MAX + 1);

	typedef logic [OUT_CREDIT_W-1:0] outCreditT;

	// multiply by x in GF(2^8)
	function automatic aesByteT gfDouble(input aesByteT a);
		aesByteT shifted;
		shifted = {a[6:0], 1'b0};
		if (a[7])
			shifted = shifted ^ GF_POLY;
		return shifted;
	endfunction

endpackage

/* rtl/sboxGf.sv */
// forward AES S-box for one byte, built from a GF(2^8) inverse and the affine map
module sboxGf
(
	input aesPkg::aesByteT in,
	output aesPkg::aesByteT out
);

	// shift-and-add multiply, reducing on every doubling
	function automatic aesPkg::aesByteT gfMul
	(
		input aesPkg::aesByteT a,
		input aesPkg::aesByteT b
	);
		aesPkg::aesByteT acc;
		aesPkg::aesByteT partial;
		acc = '0;
		partial = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ partial;
			partial = aesPkg::gfDouble(partial);
		end
		return acc;
	endfunction

	aesPkg::aesByteT pow2;
	aesPkg::aesByteT pow3;
	aesPkg::aesByteT pow6;
	aesPkg::aesByteT pow7;
	aesPkg::aesByteT pow14;
	aesPkg::aesByteT pow15;
	aesPkg::aesByteT pow30;
	aesPkg::aesByteT pow31;
	aesPkg::aesByteT pow62;
	aesPkg::aesByteT pow63;
	aesPkg::aesByteT pow126;
	aesPkg::aesByteT pow127;
	aesPkg::aesByteT inv;

	// inverse is in^254, which also sends zero to zero
	assign pow2 = gfMul(in, in);
	assign pow3 = gfMul(pow2, in);
	assign pow6 = gfMul(pow3, pow3);
	assign pow7 = gfMul(pow6, in);
	assign pow14 = gfMul(pow7, pow7);
	assign pow15 = gfMul(pow14, in);
	assign pow30 = gfMul(pow15, pow15);
	assign pow31 = gfMul(pow30, in);
	assign pow62 = gfMul(pow31, pow31);
	assign pow63 = gfMul(pow62, in);
	assign pow126 = gfMul(pow63, pow63);
	assign pow127 = gfMul(pow126, in);
	assign inv = gfMul(pow127, pow127);

	// affine map as the sum of four left rotations plus the constant
	assign out = inv
		^ {inv[6:0], inv[7]}
		^ {inv[5:0], inv[7:6]}
		^ {inv[4:0], inv[7:5]}
		^ {inv[3:0], inv[7:4]}
		^ aesPkg::SBOX_AFFINE_CONST;

endmodule

/* rtl/roundFunction.sv */
// one combinational AES encryption round, with column mixing skipped in the final round
module roundFunction
(
	input aesPkg::aesBlockT stateIn,
	input aesPkg::aesBlockT roundKey,
	input logic lastRound,
	output aesPkg::aesBlockT stateOut
);

	// byte k of the block sits at row k % 4, column k / 4
	aesPkg::aesByteT subbed [16];
	aesPkg::aesByteT shifted [16];
	aesPkg::aesByteT mixed [16];

	for (genvar k = 0; k < 16; k++)
	begin : gSbox
		sboxGf sboxGf_inst
		(
			.in(stateIn[127-8*k -: 8]),
			.out(subbed[k])
		);
	end

	// row r is rotated left by r columns
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				shifted[4*c+r] = subbed[4*((c+r)%4)+r];
			end
		end
	end

	// 2a ^ 3b ^ c ^ d rewritten as a ^ colSum ^ 2(a ^ b)
	always_comb
	begin
		aesPkg::aesByteT colSum;
		aesPkg::aesByteT pairSum;
		for (int c = 0; c < 4; c++)
		begin
			colSum = shifted[4*c] ^ shifted[4*c+1] ^ shifted[4*c+2] ^ shifted[4*c+3];
			for (int r = 0; r < 4; r++)
			begin
				pairSum = shifted[4*c+r] ^ shifted[4*c+(r+1)%4];
				mixed[4*c+r] = shifted[4*c+r] ^ colSum ^ aesPkg::gfDouble(pairSum);
			end
		end
	end

	// key addition closes every round
	always_comb
	begin
		for (int k = 0; k < 16; k++)
		begin
			if (lastRound)
				stateOut[127-8*k -: 8] = shifted[k] ^ roundKey[127-8*k -: 8];
			else
				stateOut[127-8*k -: 8] = mixed[k] ^ roundKey[127-8*k -: 8];
		end
	end

endmodule

/* rtl/keyExpander.sv */
// on-the-fly AES-128 key schedule that offers the key of the next round each cycle
module keyExpander
(
	input logic clk,
	input logic arstN,
	input logic load,
	input logic step,
	input aesPkg::aesBlockT keyIn,
	output aesPkg::aesBlockT roundKey
);

	aesPkg::aesBlockT keyReg;
	aesPkg::aesByteT rcon;
	aesPkg::aesWordT rotWord;
	aesPkg::aesByteT subbed [4];
	aesPkg::aesWordT temp;
	aesPkg::aesWordT nextW0;
	aesPkg::aesWordT nextW1;
	aesPkg::aesWordT nextW2;
	aesPkg::aesWordT nextW3;

	// last word of the current key, rotated one byte left
	assign rotWord = {keyReg[23:0], keyReg[31:24]};

	for (genvar b = 0; b < 4; b++)
	begin : gSbox
		sboxGf sboxGf_inst
		(
			.in(rotWord[31-8*b -: 8]),
			.out(subbed[b])
		);
	end

	assign temp = {subbed[0], subbed[1], subbed[2], subbed[3]} ^ {rcon, 24'h000000};

	// each word chains through the one before it
	assign nextW0 = keyReg[127:96] ^ temp;
	assign nextW1 = keyReg[95:64] ^ nextW0;
	assign nextW2 = keyReg[63:32] ^ nextW1;
	assign nextW3 = keyReg[31:0] ^ nextW2;

	assign roundKey = {nextW0, nextW1, nextW2, nextW3};

	always_ff @(posedge clk)
	begin
		if (load)
			keyReg <= keyIn;
		else if (step)
			keyReg <= roundKey;
	end

	// constant runs 01, 02, 04 ... 80, 1b, 36
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			rcon <= aesPkg::RCON_INIT;
		else if (load)
			rcon <= aesPkg::RCON_INIT;
		else if (step)
			rcon <= aesPkg::gfDouble(rcon);
	end

endmodule

/* rtl/aesCore.sv */
// iterative AES-128 encryption core that runs one block through ten rounds, one per clock
module aesCore
(
	input logic clk,
	input logic arstN,
	input logic startValid,
	input aesPkg::aesBlockT startData,
	input aesPkg::aesBlockT startKey,
	output logic startTaken,
	output logic resultValid,
	output aesPkg::aesBlockT resultData,
	input logic resultTaken
);

	aesPkg::coreStateT coreState;
	aesPkg::roundIndexT roundCnt;
	aesPkg::aesBlockT stateReg;
	aesPkg::aesBlockT roundKey;
	aesPkg::aesBlockT roundOut;
	logic inRound;
	logic lastRound;

	assign inRound = (coreState == aesPkg::CORE_ROUND);
	assign lastRound = (roundCnt == aesPkg::NUM_ROUNDS);
	assign resultValid = (coreState == aesPkg::CORE_HOLD);
	assign resultData = stateReg;

	// a new block enters when idle or as the held result leaves
	assign startTaken = startValid
		&& ((coreState == aesPkg::CORE_IDLE) || (resultValid && resultTaken));

	keyExpander keyExpander_inst
	(
		.clk(clk),
		.arstN(arstN),
		.load(startTaken),
		.step(inRound),
		.keyIn(startKey),
		.roundKey(roundKey)
	);

	roundFunction roundFunction_inst
	(
		.stateIn(stateReg),
		.roundKey(roundKey),
		.lastRound(lastRound),
		.stateOut(roundOut)
	);

	// load cycle does the initial key addition
	always_ff @(posedge clk)
	begin
		if (startTaken)
			stateReg <= startData ^ startKey;
		else if (inRound)
			stateReg <= roundOut;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			coreState <= aesPkg::CORE_IDLE;
			roundCnt <= '0;
		end
		else if (startTaken)
		begin
			coreState <= aesPkg::CORE_ROUND;
			roundCnt <= 4'd1;
		end
		else
		begin
			case (coreState)
				aesPkg::CORE_ROUND:
				begin
					if (lastRound)
						coreState <= aesPkg::CORE_HOLD;
					else
						roundCnt <= roundCnt + 4'd1;
				end
				aesPkg::CORE_HOLD:
				begin
					if (resultTaken)
						coreState <= aesPkg::CORE_IDLE;
				end
				default:
					coreState <= aesPkg::CORE_IDLE;
			endcase
		end
	end

	// round count stays within 1 to NUM_ROUNDS while rounds run
	roundRangeA: assert property (@(posedge clk) disable iff (!arstN)
		inRound |-> (roundCnt >= 4'd1) && (roundCnt <= aesPkg::NUM_ROUNDS));

	// top level only takes a result that is on offer
	resultTakenA: assert property (@(posedge clk) disable iff (!arstN)
		resultTaken |-> resultValid);

endmodule

/* rtl/aesCreditTop.sv */
// AES-128 encryption engine top level with credit-based input and output channels
module aesCreditTop
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input aesPkg::aesBlockT inData,
	input aesPkg::aesBlockT inKey,
	output logic inCredit,
	input logic outCredit,
	output logic outValid,
	output aesPkg::aesBlockT outData
);

	logic slotFull;
	aesPkg::aesBlockT slotData;
	aesPkg::aesBlockT slotKey;
	logic startValid;
	aesPkg::aesBlockT startData;
	aesPkg::aesBlockT startKey;
	logic startTaken;
	logic resultValid;
	aesPkg::aesBlockT resultData;
	logic resultTaken;
	logic creditIssued;
	aesPkg::outCreditT outCount;

	// an empty slot hands an arriving block straight to the core
	assign startValid = slotFull || inValid;
	assign startData = slotFull ? slotData : inData;
	assign startKey = slotFull ? slotKey : inKey;

	aesCore aesCore_inst
	(
		.clk(clk),
		.arstN(arstN),
		.startValid(startValid),
		.startData(startData),
		.startKey(startKey),
		.startTaken(startTaken),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultTaken(resultTaken)
	);

	always_ff @(posedge clk)
	begin
		if (!slotFull && inValid)
		begin
			slotData <= inData;
			slotKey <= inKey;
		end
	end

	// one credit after reset, then one back per block the core takes
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			slotFull <= 1'b0;
			creditIssued <= 1'b0;
			inCredit <= 1'b0;
		end
		else
		begin
			slotFull <= slotFull ? !startTaken : (inValid && !startTaken);
			creditIssued <= 1'b1;
			inCredit <= !creditIssued || startTaken;
		end
	end

	assign resultTaken = resultValid && (outCount != '0);

	// credit is spent in the cycle the result moves to the output register
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outCount <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= resultTaken;
			if (outCredit && !resultTaken)
			begin
				if (outCount != aesPkg::outCreditT'(aesPkg::OUT_CREDIT_MAX))
					outCount <= outCount + 1'b1;
			end
			else if (!outCredit && resultTaken)
				outCount <= outCount - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (resultTaken)
			outData <= resultData;
	end

	// upstream sends only while it holds a credit
	slotOverflowA: assert property (@(posedge clk) disable iff (!arstN)
		inValid |-> !slotFull);

	outCreditA: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> ($past(outCount) != '0));

endmodule

/* include/aesTbTasks.svh */
// directed test tasks, check helpers and known-answer vectors, included inside the aesTb module
`ifndef AES_TB_TASKS_SVH
`define AES_TB_TASKS_SVH

	// standard AES-128 known-answer vectors
	function automatic aesPkg::aesBlockT vectorKey(input int idx);
		case (idx)
			0: return 128'h000102030405060708090a0b0c0d0e0f;
			1: return 128'h2b7e151628aed2a6abf7158809cf4f3c;
			default: return '0;
		endcase
	endfunction

	function automatic aesPkg::aesBlockT vectorPlain(input int idx);
		case (idx)
			0: return 128'h00112233445566778899aabbccddeeff;
			1: return 128'h3243f6a8885a308d313198a2e0370734;
			default: return '0;
		endcase
	endfunction

	function automatic aesPkg::aesBlockT vectorCipher(input int idx);
		case (idx)
			0: return 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
			1: return 128'h3925841d02dc09fbdc118597196a0b32;
			default: return 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
		endcase
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input aesPkg::aesBlockT expected,
		input aesPkg::aesBlockT actual);
		if (actual !== expected)
			abortRun($sformatf("mismatch in %s: expected %h, actual %h",
				testName, expected, actual));
	endtask

	// inputs change one time unit after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
			nextCycle();
	endtask

	// one valid cycle spends one input credit
	task automatic sendBlock(input int idx);
		int waited;
		waited = 0;
		while (inCreditCount <= sentCount)
		begin
			if (waited == WAIT_LIMIT)
				abortRun("no input credit arrived while waiting to send a block");
			nextCycle();
			waited++;
		end
		inValid = 1'b1;
		inKey = vectorKey(idx);
		inData = vectorPlain(idx);
		sentCount++;
		nextCycle();
		inValid = 1'b0;
	endtask

	// the DUT counter saturates, so outstanding credits stay within its limit
	task automatic grantCredit();
		while (outCreditCount - outValidCount >= CREDIT_LIMIT)
			nextCycle();
		outCredit = 1'b1;
		nextCycle();
		outCredit = 1'b0;
	endtask

	task automatic checkResults(input string testName, input int first, input int count);
		int waited;
		waited = 0;
		while (results.size() < count)
		begin
			if (waited == WAIT_LIMIT)
				abortRun($sformatf("%s timed out waiting for a result", testName));
			nextCycle();
			waited++;
		end
		for (int i = 0; i < count; i++)
			checkValue(testName, vectorCipher((first + i) % 3), results.pop_front());
	endtask

	task automatic resetCreditTest();
		idleCycles(SETTLE_CYCLES);
		checkValue("resetCredit", 1, inCreditCount);
	endtask

	// idle core with an output credit already held
	task automatic knownAnswerTest();
		grantCredit();
		idleCycles(2);
		sendBlock(0);
		checkResults("knownAnswer", 0, 1);
		checkValue("knownAnswerLatency", RESULT_LATENCY, lastOutCycle - lastInCycle);
	endtask

	task automatic furtherKnownAnswerTest();
		for (int idx = 1; idx < 3; idx++)
		begin
			grantCredit();
			sendBlock(idx);
			checkResults("furtherKnownAnswer", idx, 1);
		end
	endtask

	task automatic streamingTest();
		repeat (3)
			grantCredit();
		for (int idx = 0; idx < 3; idx++)
			sendBlock(idx);
		checkResults("streaming", 0, 3);
	endtask

	// second block waits in the slot while the first result is held
	task automatic backPressureTest();
		int baseOut;
		baseOut = outValidCount;
		sendBlock(0);
		sendBlock(1);
		idleCycles(STALL_CYCLES);
		checkValue("backPressureStall", baseOut, outValidCount);
		checkValue("backPressureInCredit", sentCount, inCreditCount);
		for (int i = 0; i < 2; i++)
		begin
			grantCredit();
			checkResults("backPressure", i, 1);
			// gap outlasts a block's latency, so a result without credit would show
			idleCycles(RESULT_LATENCY + $urandom % 7);
			checkValue("backPressureOnePerCredit", 0, results.size());
		end
	endtask

	task automatic creditAccountingTest();
		int sendGap [6];
		int creditGap [6];
		for (int i = 0; i < 6; i++)
		begin
			sendGap[i] = $urandom % 8;
			creditGap[i] = $urandom % 8;
		end
		fork
			begin
				for (int i = 0; i < 6; i++)
				begin
					idleCycles(sendGap[i]);
					sendBlock(i % 3);
				end
			end
			begin
				for (int i = 0; i < 6; i++)
				begin
					idleCycles(creditGap[i]);
					grantCredit();
				end
			end
		join
		checkResults("creditAccounting", 0, 6);
		checkValue("inCreditBalance", sentCount + 1, inCreditCount);
		checkValue("outCreditBalance", outCreditCount, outValidCount);
	endtask

`endif

/* testbench/aesTb.sv */
// testbench top for the AES-128 credit engine, compiled with src.f and run with aesTb as top
module aesTb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_SEED = 78263;
	localparam int CREDIT_LIMIT = 4;
	localparam int STALL_CYCLES = 60;
	localparam int SETTLE_CYCLES = 8;
	localparam int TOTAL_BLOCKS = 14;
	localparam int BLOCK_CYCLES = 40;
	localparam int WAIT_LIMIT = 200;
	// cycles from an inValid cycle to outValid with an idle core and a credit held
	localparam int RESULT_LATENCY = 12;
	// every block gets its budget, plus reset, settle time and the stall watch
	localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * BLOCK_CYCLES + RESET_CYCLES
		+ SETTLE_CYCLES + STALL_CYCLES;

	logic clk;
	logic arstN;
	logic inValid;
	aesPkg::aesBlockT inData;
	aesPkg::aesBlockT inKey;
	logic inCredit;
	logic outCredit;
	logic outValid;
	aesPkg::aesBlockT outData;

	// channel activity seen by the credit sink
	int cycleCount;
	int inCreditCount;
	int outCreditCount;
	int outValidCount;
	int sentCount;
	int lastInCycle;
	int lastOutCycle;
	aesPkg::aesBlockT results [$];

	aesCreditTop aesCreditTop_inst
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inData(inData),
		.inKey(inKey),
		.inCredit(inCredit),
		.outCredit(outCredit),
		.outValid(outValid),
		.outData(outData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	`include "aesTbTasks.svh"

	// sampled at the falling edge, halfway between drive points
	always @(negedge clk)
	begin
		cycleCount++;
		if (arstN)
		begin
			if (inCredit)
				inCreditCount++;
			if (outCredit)
				outCreditCount++;
			if (inValid)
				lastInCycle = cycleCount;
			if (outValid)
			begin
				outValidCount++;
				lastOutCycle = cycleCount;
				results.push_back(outData);
				if (outValidCount > outCreditCount)
					abortRun("outValid fired without a granted output credit");
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("watchdog expired before the test sequence finished");
	end

	initial
	begin
		void'($urandom(RANDOM_SEED));
		arstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		inKey = '0;
		outCredit = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arstN = 1'b1;
		resetCreditTest();
		knownAnswerTest();
		furtherKnownAnswerTest();
		streamingTest();
		backPressureTest();
		creditAccountingTest();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
rtl/aesPkg.sv
rtl/sboxGf.sv
rtl/roundFunction.sv
rtl/keyExpander.sv
rtl/aesCore.sv
rtl/aesCreditTop.sv
testbench/aesTb.sv
